//--- hdl/conv5_cfg.svh
`ifndef CONV5_CFG_SVH
`define CONV5_CFG_SVH

// frame geometry
`define CONV5_ROWS 7
`define CONV5_COLS 7

// row and col index width
`define CONV5_POS_W 4

// data widths
`define CONV5_PIX_W 8
`define CONV5_COEF_W 8
`define CONV5_ACC_W 24

// zero steps needed to push the last centre through the window
`define CONV5_FLUSH (2 * `CONV5_COLS + 2)

`endif

//--- hdl/conv5_pkg.sv
`default_nettype none
`include "conv5_cfg.svh"

package conv5_pkg;

  typedef logic [`CONV5_PIX_W-1:0] pix_t;

  typedef struct packed {
    logic [`CONV5_POS_W-1:0] row;
    logic [`CONV5_POS_W-1:0] col;
  } pos_t;

  typedef struct packed {
    logic shift;
    logic emit;
    pix_t pix;
    pos_t center;
  } step_t;

  // px[0] is the oldest row
  typedef struct packed {
    pix_t [4:0] px;
  } col_t;

  // px[0] is top-left in raster order
  typedef struct packed {
    pix_t [24:0] px;
  } window_t;

  typedef struct packed {
    logic    valid;
    pos_t    center;
    window_t win;
  } win_beat_t;

  typedef struct packed {
    pos_t center;
    pix_t value;
  } result_t;

  typedef struct packed {
    logic                            kind;
    logic [4:0]                      idx;
    logic [1:0]                      spare;
    logic signed [`CONV5_COEF_W-1:0] coef;
  } cfg_coef_t;

  typedef struct packed {
    logic                            kind;
    logic [2:0]                      spare;
    logic [3:0]                      shift;
    logic signed [`CONV5_COEF_W-1:0] bias;
  } cfg_scale_t;

  // kind selects the view
  typedef union packed {
    cfg_coef_t  coef;
    cfg_scale_t scale;
  } cfg_word_u;

endpackage

`default_nettype wire

//--- hdl/frame_sequencer.sv
`timescale 1ns/100ps
`default_nettype none
`include "conv5_cfg.svh"

module frame_sequencer import conv5_pkg::*; (
  input  wire        clk,
  input  wire        rst_n,
  input  wire        pix_valid,
  input  wire  pix_t pix,
  input  wire        done_tick,
  output step_t      step,
  output logic       busy
);

  localparam int FRAME = `CONV5_ROWS * `CONV5_COLS;
  localparam int TOTAL = FRAME + `CONV5_FLUSH;
  localparam int CNT_W = $clog2(TOTAL);
  localparam int POS_W = `CONV5_POS_W;

  localparam logic [POS_W-1:0] LAST_ROW = POS_W'(`CONV5_ROWS - 1);
  localparam logic [POS_W-1:0] LAST_COL = POS_W'(`CONV5_COLS - 1);

  logic [CNT_W-1:0] pos;
  logic             flushing;
  pos_t             center;
  logic             shift_now;
  logic             lead_done;

  // flush steps are self-timed, one per cycle
  assign shift_now = flushing || pix_valid;
  assign lead_done = (pos >= CNT_W'(`CONV5_FLUSH));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pos      <= '0;
      flushing <= 1'b0;
      center   <= '0;
      step     <= '0;
      busy     <= 1'b0;
    end else begin
      step.shift  <= shift_now;
      step.emit   <= shift_now && lead_done;
      step.pix    <= flushing ? '0 : pix;
      step.center <= center;

      if (shift_now) begin
        if (pos == CNT_W'(TOTAL - 1)) begin
          pos      <= '0;
          flushing <= 1'b0;
        end else begin
          pos <= pos + 1'b1;
        end
        if (pos == CNT_W'(FRAME - 1)) begin
          flushing <= 1'b1;
        end
        // centre advances only once the window has filled
        if (lead_done) begin
          if (center.col == LAST_COL) begin
            center.col <= '0;
            center.row <= (center.row == LAST_ROW) ? '0 : center.row + 1'b1;
          end else begin
            center.col <= center.col + 1'b1;
          end
        end
      end

      // a new frame may start before the last result of the previous one
      if (shift_now && pos == '0) begin
        busy <= 1'b1;
      end else if (done_tick && pos == '0) begin
        busy <= 1'b0;
      end
    end
  end

  a_no_pix_in_flush: assert property (@(posedge clk) disable iff (!rst_n)
    flushing |-> !pix_valid)
    else $error("pixel strobe during flush");

endmodule

`default_nettype wire

//--- hdl/line_buffer.sv
`timescale 1ns/100ps
`default_nettype none
`include "conv5_cfg.svh"

module line_buffer import conv5_pkg::*; (
  input  wire        clk,
  input  wire        rst_n,
  input  wire step_t step,
  output col_t       column
);

  localparam int COLS = `CONV5_COLS;

  pix_t chain [4][COLS];
  pix_t feed  [4];

  // each chain is fed by the tail of the one below it
  always_comb begin
    feed[0] = step.pix;
    for (int k = 1; k < 4; k++) begin
      feed[k] = chain[k-1][COLS-1];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      chain <= '{default: '0};
    end else if (step.shift) begin
      for (int k = 0; k < 4; k++) begin
        chain[k][0] <= feed[k];
        for (int i = 1; i < COLS; i++) begin
          chain[k][i] <= chain[k][i-1];
        end
      end
    end
  end

  // bottom is the current pixel, top is four rows back
  always_comb begin
    column.px[4] = step.pix;
    for (int k = 0; k < 4; k++) begin
      column.px[3-k] = chain[k][COLS-1];
    end
  end

endmodule

`default_nettype wire

//--- hdl/window_5x5.sv
`timescale 1ns/100ps
`default_nettype none
`include "conv5_cfg.svh"

module window_5x5 import conv5_pkg::*; (
  input  wire        clk,
  input  wire        rst_n,
  input  wire step_t step,
  input  wire col_t  column,
  output win_beat_t  beat
);

  localparam int ROWS  = `CONV5_ROWS;
  localparam int COLS  = `CONV5_COLS;
  localparam int POS_W = `CONV5_POS_W;

  // in win_q[r][j] row 0 is the oldest and col 0 the leftmost
  pix_t [4:0][4:0] win_q;
  logic            emit_d;
  pos_t            center_d;
  logic [4:0]      row_ok;
  logic [4:0]      col_ok;
  window_t         padded;

  always_ff @(posedge clk) begin
    if (step.shift) begin
      for (int r = 0; r < 5; r++) begin
        for (int j = 0; j < 4; j++) begin
          win_q[r][j] <= win_q[r][j+1];
        end
        win_q[r][4] <= column.px[r];
      end
    end
  end

  // masks also catch columns that wrap in from the neighbouring row
  always_comb begin
    int tr;
    int tc;
    for (int k = 0; k < 5; k++) begin
      tr = int'(center_d.row) + k - 2;
      tc = int'(center_d.col) + k - 2;
      row_ok[k] = (tr >= 0) && (tr < ROWS);
      col_ok[k] = (tc >= 0) && (tc < COLS);
    end
    for (int r = 0; r < 5; r++) begin
      for (int j = 0; j < 5; j++) begin
        padded.px[r*5+j] = (row_ok[r] && col_ok[j]) ? win_q[r][j] : '0;
      end
    end
  end

  always_ff @(posedge clk) begin
    center_d    <= step.center;
    beat.center <= center_d;
    beat.win    <= padded;
    if (!rst_n) begin
      emit_d     <= 1'b0;
      beat.valid <= 1'b0;
    end else begin
      emit_d     <= step.emit;
      beat.valid <= emit_d;
    end
  end

  a_center_in_frame: assert property (@(posedge clk) disable iff (!rst_n)
    step.emit |-> (step.center.row < POS_W'(ROWS)) && (step.center.col < POS_W'(COLS)))
    else $error("window centre outside frame");

endmodule

`default_nettype wire

//--- hdl/conv_mac.sv
`timescale 1ns/100ps
`default_nettype none
`include "conv5_cfg.svh"

module conv_mac import conv5_pkg::*; (
  input  wire            clk,
  input  wire            rst_n,
  input  wire            cfg_valid,
  input  wire cfg_word_u cfg,
  input  wire win_beat_t beat,
  output logic           res_valid,
  output result_t        res,
  output logic           done_tick
);

  localparam int TAPS   = 25;
  localparam int PIX_W  = `CONV5_PIX_W;
  localparam int COEF_W = `CONV5_COEF_W;
  localparam int ACC_W  = `CONV5_ACC_W;
  localparam int POS_W  = `CONV5_POS_W;
  localparam int PROD_W = COEF_W + PIX_W + 1;

  localparam logic signed [ACC_W-1:0] PIX_MAX = ACC_W'((1 << PIX_W) - 1);
  localparam pos_t LAST = '{row: POS_W'(`CONV5_ROWS - 1), col: POS_W'(`CONV5_COLS - 1)};

  logic signed [COEF_W-1:0] kernel [TAPS];
  logic signed [COEF_W-1:0] bias;
  logic [3:0]               shift;

  logic                     v1;
  logic                     v2;
  pos_t                     c1;
  pos_t                     c2;
  logic signed [PROD_W-1:0] prod [TAPS];
  logic signed [ACC_W-1:0]  tree_sum;
  logic signed [ACC_W-1:0]  acc2;
  logic signed [ACC_W-1:0]  scaled;
  pix_t                     clamped;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      kernel <= '{default: '0};
      bias   <= '0;
      shift  <= '0;
    end else if (cfg_valid) begin
      if (!cfg.coef.kind) begin
        if (cfg.coef.idx < 5'(TAPS)) begin
          kernel[cfg.coef.idx] <= cfg.coef.coef;
        end
      end else begin
        bias  <= cfg.scale.bias;
        shift <= cfg.scale.shift;
      end
    end
  end

  // stage 1 pads the unsigned pixels with a zero sign bit
  always_ff @(posedge clk) begin
    for (int i = 0; i < TAPS; i++) begin
      prod[i] <= kernel[i] * $signed({1'b0, beat.win.px[i]});
    end
    c1 <= beat.center;
    if (!rst_n) begin
      v1 <= 1'b0;
    end else begin
      v1 <= beat.valid;
    end
  end

  // stage 2
  always_comb begin
    tree_sum = ACC_W'(bias);
    for (int i = 0; i < TAPS; i++) begin
      tree_sum = tree_sum + ACC_W'(prod[i]);
    end
  end

  always_ff @(posedge clk) begin
    acc2 <= tree_sum;
    c2   <= c1;
    if (!rst_n) begin
      v2 <= 1'b0;
    end else begin
      v2 <= v1;
    end
  end

  // stage 3
  always_comb begin
    scaled = acc2 >>> shift;
    if (scaled < 0) begin
      clamped = '0;
    end else if (scaled > PIX_MAX) begin
      clamped = '1;
    end else begin
      clamped = scaled[PIX_W-1:0];
    end
  end

  always_ff @(posedge clk) begin
    res.center <= c2;
    res.value  <= clamped;
    if (!rst_n) begin
      res_valid <= 1'b0;
      done_tick <= 1'b0;
    end else begin
      res_valid <= v2;
      done_tick <= v2 && (c2 == LAST);
    end
  end

  a_coef_idx: assert property (@(posedge clk) disable iff (!rst_n)
    cfg_valid && !cfg.coef.kind |-> cfg.coef.idx < 5'(TAPS))
    else $error("coefficient index out of range");

  a_cfg_quiet: assert property (@(posedge clk) disable iff (!rst_n)
    cfg_valid |-> !(beat.valid || v1 || v2))
    else $error("config write with a window in flight");

endmodule

`default_nettype wire

//--- hdl/conv5_top.sv
`timescale 1ns/100ps
`default_nettype none

module conv5_top import conv5_pkg::*; (
  input  wire            clk,
  input  wire            rst_n,
  input  wire            pix_valid,
  input  wire pix_t      pix,
  input  wire            cfg_valid,
  input  wire cfg_word_u cfg,
  output logic           res_valid,
  output result_t        res,
  output logic           busy
);

  step_t     step;
  col_t      column;
  win_beat_t beat;
  logic      done_tick;

  frame_sequencer u_seq (
    .clk       (clk),
    .rst_n     (rst_n),
    .pix_valid (pix_valid),
    .pix       (pix),
    .done_tick (done_tick),
    .step      (step),
    .busy      (busy)
  );

  line_buffer u_lbuf (
    .clk    (clk),
    .rst_n  (rst_n),
    .step   (step),
    .column (column)
  );

  window_5x5 u_win (
    .clk    (clk),
    .rst_n  (rst_n),
    .step   (step),
    .column (column),
    .beat   (beat)
  );

  conv_mac u_mac (
    .clk       (clk),
    .rst_n     (rst_n),
    .cfg_valid (cfg_valid),
    .cfg       (cfg),
    .beat      (beat),
    .res_valid (res_valid),
    .res       (res),
    .done_tick (done_tick)
  );

endmodule

`default_nettype wire

//--- sim/conv5_tb.sv
`timescale 1ns/100ps
`default_nettype none
`include "conv5_cfg.svh"

module conv5_tb import conv5_pkg::*; ;

  localparam int ROWS   = `CONV5_ROWS;
  localparam int COLS   = `CONV5_COLS;
  localparam int FRAME  = ROWS * COLS;
  localparam int FLUSH  = `CONV5_FLUSH;
  localparam int REC    = 43;

  logic      clk;
  logic      rst_n;
  logic      pix_valid;
  pix_t      pix;
  logic      cfg_valid;
  cfg_word_u cfg;
  logic      res_valid;
  result_t   res;
  logic      busy;

  logic [7:0]  mem [0:511];
  logic [15:0] lfsr;
  int          img [2][ROWS][COLS];
  int          cur_k [25];
  int          cur_shift;
  int          cur_bias;
  int          spot_n;
  int          spot_r [4];
  int          spot_c [4];
  int          spot_v [4];
  int          total_res = 0;
  int          test_res = 0;
  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;
  int          limit = 0;

  conv5_top dut0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .pix_valid (pix_valid),
    .pix       (pix),
    .cfg_valid (cfg_valid),
    .cfg       (cfg),
    .res_valid (res_valid),
    .res       (res),
    .busy      (busy)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  task automatic take_bits(input int n, output logic [7:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[6:0], lfsr[0]};
    end
  endtask

  // sums the zero-padded window and the bias before the shift and clamp
  function automatic int model_value(input int slot, input int r, input int c);
    int acc;
    int tr;
    int tc;
    acc = cur_bias;
    for (int dr = 0; dr < 5; dr++) begin
      for (int dc = 0; dc < 5; dc++) begin
        tr = r + dr - 2;
        tc = c + dc - 2;
        if (tr >= 0 && tr < ROWS && tc >= 0 && tc < COLS) begin
          acc = acc + cur_k[dr*5+dc] * img[slot][tr][tc];
        end
      end
    end
    acc = acc >>> cur_shift;
    if (acc < 0) return 0;
    if (acc > 255) return 255;
    return acc;
  endfunction

  always @(posedge clk) begin
    cycles++;
    if (limit > 0 && cycles > limit) begin
      $display("timeout after %0d cycles, busy never dropped", cycles);
      $display("Simulation failed");
      $finish;
    end
  end

  // results are checked on the falling edge
  always @(negedge clk) begin
    int idx;
    int er;
    int ec;
    int slot;
    int ev;
    if (rst_n && res_valid) begin
      idx  = total_res % FRAME;
      er   = idx / COLS;
      ec   = idx % COLS;
      slot = (total_res / FRAME) % 2;
      checks++;
      assert (res.center.row == er && res.center.col == ec) else begin
        $display("Error at %0t: res.center got %0d,%0d expected %0d,%0d",
                 $time, res.center.row, res.center.col, er, ec);
        errors++;
      end
      // busy stays high until the cycle after the last result
      checks++;
      assert (busy) else begin
        $display("Error at %0t: busy got %0b expected 1", $time, busy);
        errors++;
      end
      ev = model_value(slot, er, ec);
      checks++;
      assert (res.value == ev) else begin
        $display("Error at %0t: res.value got %0d expected %0d at %0d,%0d",
                 $time, res.value, ev, er, ec);
        errors++;
      end
      for (int k = 0; k < spot_n; k++) begin
        if (spot_r[k] == er && spot_c[k] == ec) begin
          checks++;
          assert (res.value == spot_v[k]) else begin
            $display("Error at %0t: res.value got %0d expected %0d (spot %0d,%0d)",
                     $time, res.value, spot_v[k], er, ec);
            errors++;
          end
        end
      end
      total_res++;
      test_res++;
    end
  end

  initial begin
    int         ntests;
    int         base;
    int         fill;
    int         frames;
    int         gap;
    int         slot;
    int         frame_no;
    int         err0;
    logic [7:0] v;
    logic [7:0] g;
    rst_n     = 1'b0;
    pix_valid = 1'b0;
    pix       = '0;
    cfg_valid = 1'b0;
    cfg       = '0;
    lfsr      = 16'd32451;
    frame_no  = 0;
    spot_n    = 0;
    $readmemh("sim/conv5_tests.txt", mem);
    ntests = mem[0];
    assert (mem[0] !== 8'hxx && ntests > 0) else begin
      $display("test file missing or holds no tests");
      errors++;
    end
    limit = 20;
    for (int t = 0; t < ntests; t++) begin
      limit += mem[2 + t*REC] * (4 * FRAME + FLUSH + 40);
    end
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;

    for (int t = 0; t < ntests; t++) begin
      base      = 1 + t * REC;
      fill      = mem[base];
      frames    = mem[base+1];
      gap       = mem[base+2];
      cur_shift = mem[base+3];
      cur_bias  = $signed(mem[base+4]);
      for (int k = 0; k < 25; k++) begin
        cur_k[k] = $signed(mem[base+5+k]);
      end
      spot_n = mem[base+30];
      for (int k = 0; k < 4; k++) begin
        spot_r[k] = mem[base+31+3*k];
        spot_c[k] = mem[base+32+3*k];
        spot_v[k] = mem[base+33+3*k];
      end

      // kernel words go first and the scale word last
      for (int k = 0; k < 25; k++) begin
        @(posedge clk);
        cfg_valid <= 1'b1;
        cfg       <= {1'b0, 5'(k), 2'b00, mem[base+5+k]};
      end
      @(posedge clk);
      cfg <= {1'b1, 3'b000, mem[base+3][3:0], mem[base+4]};
      @(posedge clk);
      cfg_valid <= 1'b0;

      test_res = 0;
      err0     = errors;
      for (int f = 0; f < frames; f++) begin
        slot = frame_no % 2;
        frame_no++;
        for (int p = 0; p < FRAME; p++) begin
          take_bits(4, g);
          while (g < gap) begin
            @(posedge clk);
            pix_valid <= 1'b0;
            take_bits(4, g);
          end
          if (fill == 0) begin
            take_bits(8, v);
          end else begin
            v = fill[7:0];
          end
          img[slot][p / COLS][p % COLS] = v;
          @(posedge clk);
          pix_valid <= 1'b1;
          pix       <= v;
        end
        // no pixels while the sequencer flushes
        repeat (FLUSH) begin
          @(posedge clk);
          pix_valid <= 1'b0;
        end
      end

      @(negedge clk);
      while (busy) @(negedge clk);
      checks++;
      assert (test_res == frames * FRAME) else begin
        $display("test %0d gave %0d results instead of %0d",
                 t + 1, test_res, frames * FRAME);
        errors++;
      end
      $display("test %0d: %0d frames, %0d results, %0d errors, %s",
               t + 1, frames, test_res, errors - err0,
               (errors == err0) ? "ok" : "BAD");
    end

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sim/conv5_tests.txt
// hex words: test count, then per test: fill (00 = random pixels) frames gap shift bias,
// 25 coefficients top-left first, spot count, then four spot triples of row col value
07
// identity kernel on random pixels
00 01 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00 01 00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00
// all-ones kernel on a flat frame of 10, corners, edges, wrap columns
0a 01 03 00 00
01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01
04 00 00 5a 00 03 96 01 06 78 06 06 5a
// clamp to 255 and to 0 on a flat frame of 200
c8 01 00 00 80
80 00 00 00 00 00 00 00 00 00 00 00 7f 00 00 00 00 00 00 00 00 00 00 00 00
04 00 00 ff 01 01 ff 02 02 00 06 06 00
// large signed weights with a negative bias on random pixels
00 02 04 00 9c
7f 81 7f 81 7f 81 7f 81 7f 81 7f 81 7f 81 7f 81 7f 81 7f 81 7f 81 7f 81 7f
00 00 00 00 00 00 00 00 00 00 00 00 00
// shift 3 after a bias of 64, flat frame of 20
14 01 02 03 40
01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01
04 00 00 1e 00 03 2d 03 03 46 06 00 1e
// dense gaps and back-to-back frames
00 03 06 01 10
ff ff ff ff ff ff ff ff ff ff ff ff 18 ff ff ff ff ff ff ff ff ff ff ff ff
00 00 00 00 00 00 00 00 00 00 00 00 00
// new kernel after the previous frames
00 02 01 02 05
01 02 03 02 01 02 04 06 04 02 03 06 f8 06 03 02 04 06 04 02 01 02 03 02 01
00 00 00 00 00 00 00 00 00 00 00 00 00

//--- conv5.f
+incdir+hdl
hdl/conv5_pkg.sv
hdl/frame_sequencer.sv
hdl/line_buffer.sv
hdl/window_5x5.sv
hdl/conv_mac.sv
hdl/conv5_top.sv
sim/conv5_tb.sv

//--- Bender.yml
package:
  name: conv5

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/conv5_pkg.sv
      - hdl/frame_sequencer.sv
      - hdl/line_buffer.sv
      - hdl/window_5x5.sv
      - hdl/conv_mac.sv
      - hdl/conv5_top.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - sim/conv5_tb.sv
